//--- common/booth_pkg.sv
//####################################################################
// Shared types and defaults for the radix-2 Booth multiplier
//####################################################################

package booth_pkg;

    // operand width used when the top level is not overridden
    parameter int BOOTH_WIDTH = 16;

    // what happens to the accumulator before the shift
    typedef enum logic [1:0] {
        BOOTH_NONE = 2'b00,
        BOOTH_ADD  = 2'b01,
        BOOTH_SUB  = 2'b10
    } booth_op_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } ctrl_state_e;

    // bits is {q[0], q_extra}
    function automatic booth_op_e booth_recode(input logic [1:0] bits);
        booth_op_e op;
        case (bits)
            2'b10:   op = BOOTH_SUB;
            2'b01:   op = BOOTH_ADD;
            default: op = BOOTH_NONE;
        endcase
        return op;
    endfunction

endpackage

//--- common/booth_ctrl_if.sv
//####################################################################
// Control and status bundle between the Booth controller and datapath
//####################################################################

`timescale 1ns/1ps

interface booth_ctrl_if
    import booth_pkg::*;
();

    // strobes from the controller, levels sampled on the next edge
    logic      load;
    logic      step;
    booth_op_e op;
    logic      count_en;

    // status back from the datapath
    logic [1:0] booth_bits;
    logic       count_done;

    // controller side
    modport ctrl (
        output load,
        output step,
        output op,
        output count_en,
        input  booth_bits,
        input  count_done
    );

    // datapath side
    modport dp (
        input  load,
        input  step,
        input  op,
        input  count_en,
        output booth_bits,
        output count_done
    );

endinterface

//--- hw/booth_mul/booth_ctrl.sv
//####################################################################
// Two-state controller for the sequential Booth multiplier
// sequences operand load, the Booth steps and the ready pulse
//####################################################################

`timescale 1ns/1ps

module booth_ctrl
    import booth_pkg::*;
#(
    parameter int WIDTH = BOOTH_WIDTH
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    output logic         ready,
    booth_ctrl_if.ctrl   cif
);

    ctrl_state_e state;
    ctrl_state_e next_state;

    // high in the cycle where the counter has just run out
    logic run_finish;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // next state and datapath strobes
    always_comb begin
        next_state   = state;
        cif.load     = 1'b0;
        cif.step     = 1'b0;
        cif.count_en = 1'b0;
        cif.op       = BOOTH_NONE;
        run_finish   = 1'b0;

        case (state)
            ST_IDLE: begin
                // start is only looked at here
                if (start) begin
                    next_state   = ST_RUN;
                    cif.load     = 1'b1;
                    cif.step     = 1'b0;
                    cif.count_en = 1'b0;
                    cif.op       = BOOTH_NONE;
                end else begin
                    next_state   = ST_IDLE;
                    cif.load     = 1'b0;
                    cif.step     = 1'b0;
                    cif.count_en = 1'b0;
                    cif.op       = BOOTH_NONE;
                end
                run_finish = 1'b0;
            end

            ST_RUN: begin
                cif.load = 1'b0;
                if (cif.count_done) begin
                    // all steps taken, product is final
                    next_state   = ST_IDLE;
                    cif.step     = 1'b0;
                    cif.count_en = 1'b0;
                    cif.op       = BOOTH_NONE;
                    run_finish   = 1'b1;
                end else begin
                    next_state   = ST_RUN;
                    cif.step     = 1'b1;
                    cif.count_en = 1'b1;
                    cif.op       = booth_recode(cif.booth_bits);
                    run_finish   = 1'b0;
                end
            end

            default: begin
                next_state   = ST_IDLE;
                cif.load     = 1'b0;
                cif.step     = 1'b0;
                cif.count_en = 1'b0;
                cif.op       = BOOTH_NONE;
                run_finish   = 1'b0;
            end
        endcase
    end

    // ready pulses for one cycle as the state returns to idle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ready <= 1'b0;
        end else begin
            ready <= run_finish;
        end
    end

endmodule

//--- hw/booth_mul/booth_datapath.sv
//####################################################################
// Booth multiplier datapath with A, Q and M registers, add/subtract,
// arithmetic right shift and the step counter
//####################################################################

`timescale 1ns/1ps

module booth_datapath
    import booth_pkg::*;
#(
    parameter int WIDTH = BOOTH_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic signed [WIDTH-1:0] multiplicand,
    input  logic signed [WIDTH-1:0] multiplier,
    output logic signed [2*WIDTH-1:0] product,
    booth_ctrl_if.dp                dif
);

    // counter has to hold the value WIDTH itself
    localparam int CNT_W = $clog2(WIDTH + 1);

    logic signed [WIDTH-1:0] m_reg;
    logic signed [WIDTH-1:0] a_reg;
    logic        [WIDTH-1:0] q_reg;
    logic                    q_extra;
    logic        [CNT_W-1:0] count;

    // one extra bit so that A - M with M at its minimum keeps its sign
    logic signed [WIDTH:0] a_ext;
    logic signed [WIDTH:0] m_ext;
    logic signed [WIDTH:0] sum;

    // shifted results
    logic signed [WIDTH-1:0] a_next;
    logic        [WIDTH-1:0] q_next;
    logic                    q_extra_next;

    assign a_ext = {a_reg[WIDTH-1], a_reg};
    assign m_ext = {m_reg[WIDTH-1], m_reg};

    always_comb begin
        case (dif.op)
            BOOTH_ADD: sum = a_ext + m_ext;
            BOOTH_SUB: sum = a_ext - m_ext;
            default:   sum = a_ext;
        endcase
    end

    // arithmetic shift of {sum, q, extra} by one
    // sum[WIDTH] carries the true sign into A
    always_comb begin
        a_next       = sum[WIDTH:1];
        q_next       = {sum[0], q_reg[WIDTH-1:1]};
        q_extra_next = q_reg[0];
    end

    // multiplicand only changes on load
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            m_reg <= '0;
        end else if (dif.load) begin
            m_reg <= multiplicand;
        end
    end

    // accumulator and multiplier shift register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            a_reg   <= '0;
            q_reg   <= '0;
            q_extra <= 1'b0;
        end else if (dif.load) begin
            a_reg   <= '0;
            q_reg   <= multiplier;
            q_extra <= 1'b0;
        end else if (dif.step) begin
            a_reg   <= a_next;
            q_reg   <= q_next;
            q_extra <= q_extra_next;
        end
    end

    // steps left in the current run
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (dif.load) begin
            count <= CNT_W'(WIDTH);
        end else if (dif.count_en) begin
            count <= count - 1'b1;
        end
    end

    // status for the controller
    assign dif.booth_bits = {q_reg[0], q_extra};
    assign dif.count_done = (count == '0);

    // product sits in {A, Q} once the last shift is done
    assign product = {a_reg, q_reg};

endmodule

//--- hw/booth_mul_top.sv
//####################################################################
// Top level of the 16-bit signed sequential Booth multiplier
//####################################################################

`timescale 1ns/1ps

module booth_mul_top
    import booth_pkg::*;
#(
    parameter int WIDTH = BOOTH_WIDTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic signed [WIDTH-1:0]   multiplicand,
    input  logic signed [WIDTH-1:0]   multiplier,
    output logic signed [2*WIDTH-1:0] product,
    output logic                      ready
);

    // strobes and status between the two halves
    booth_ctrl_if ctrl_bus ();

    booth_ctrl #(
        .WIDTH (WIDTH)
    ) u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .ready (ready),
        .cif   (ctrl_bus.ctrl)
    );

    booth_datapath #(
        .WIDTH (WIDTH)
    ) u_datapath (
        .clk          (clk),
        .rst          (rst),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .dif          (ctrl_bus.dp)
    );

endmodule

//--- testbench/tb_clk_gen.sv
//####################################################################
// Clock and reset source for the Booth multiplier testbench
//####################################################################

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // reset held low for the first cycles, released on a rising edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

//--- testbench/tb_booth_mul.sv
//####################################################################
// Directed testbench for the sequential Booth multiplier
// checks products, ready latency and start handling
//####################################################################

`timescale 1ns/1ps

module tb_booth_mul
    import booth_pkg::*;
();

    localparam int WIDTH          = BOOTH_WIDTH;
    localparam int LATENCY        = WIDTH + 1;
    localparam int READY_LIMIT    = LATENCY + 8;
    localparam int TIMEOUT_CYCLES = 12000;
    localparam int RANDOM_PAIRS   = 200;
    localparam int IDLE_HOLD      = 10;
    localparam int SEED           = 95115;

    logic               clk;
    logic               rst;
    logic               start;
    logic [WIDTH-1:0]   multiplicand;
    logic [WIDTH-1:0]   multiplier;
    logic [2*WIDTH-1:0] product;
    logic               ready;

    int cycle_count = 0;

    tb_clk_gen #(
        .PERIOD_NS    (4.0),
        .RESET_CYCLES (4)
    ) u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    booth_mul_top #(
        .WIDTH (WIDTH)
    ) u_booth_mul_top (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .ready        (ready)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("mismatch %s: expected 0x%0h, got 0x%0h",
                               name, expected, actual));
        end
    endtask

    // signed product of two operands, plain arithmetic
    function automatic logic [2*WIDTH-1:0] model_product(input logic [WIDTH-1:0] a,
                                                         input logic [WIDTH-1:0] b);
        logic signed [2*WIDTH-1:0] full;
        full = $signed(a) * $signed(b);
        return full;
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    // counts rising edges until ready is seen, ends at the negedge of the ready cycle
    task automatic wait_for_ready(inout int edges);
        bit seen;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (ready === 1'b1) begin
                seen = 1'b1;
            end else if (edges >= READY_LIMIT) begin
                fail_run("ready never rose after an accepted start");
            end
        end
    endtask

    // one full operation with latency, pulse width and product checks
    task automatic multiply_once(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        int               edges;
        logic [2*WIDTH-1:0] expected;
        expected = model_product(a, b);
        @(posedge clk);
        start        <= 1'b1;
        multiplicand <= a;
        multiplier   <= b;
        // start-sampling edge
        @(posedge clk);
        start <= 1'b0;
        edges = 0;
        wait_for_ready(edges);
        check_value("ready latency", LATENCY, edges);
        check_value("product", expected, product);
        @(posedge clk);
        @(negedge clk);
        check_value("ready", 1'b0, ready);
        check_value("product", expected, product);
    endtask

    task automatic check_reset_state();
        // still inside reset here
        @(negedge clk);
        check_value("ready", 1'b0, ready);
        check_value("product", '0, product);
        wait (rst === 1'b1);
        repeat (5) begin
            @(negedge clk);
            check_value("ready", 1'b0, ready);
            check_value("product", '0, product);
        end
    endtask

    task automatic run_corner_operands();
        logic [WIDTH-1:0] corners [5];
        logic [WIDTH-1:0] min_val;
        min_val    = {1'b1, {(WIDTH-1){1'b0}}};
        corners[0] = '0;
        corners[1] = WIDTH'(1);
        corners[2] = '1;
        corners[3] = {1'b0, {(WIDTH-1){1'b1}}};
        corners[4] = min_val;
        foreach (corners[i]) begin
            foreach (corners[j]) begin
                multiply_once(corners[i], corners[j]);
            end
        end
        // most negative squared is the one case that reaches the top bits
        multiply_once(min_val, min_val);
        check_value("product", 64'(1) << (2*WIDTH-2), product);
    endtask

    task automatic run_random_operands();
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        repeat (RANDOM_PAIRS) begin
            a = WIDTH'($urandom());
            b = WIDTH'($urandom());
            multiply_once(a, b);
        end
    endtask

    // a second start mid-run has to leave the first operation untouched
    task automatic ignore_start_while_busy();
        int                 edges;
        logic [WIDTH-1:0]   a1;
        logic [WIDTH-1:0]   b1;
        logic [2*WIDTH-1:0] expected;
        a1       = WIDTH'(16'h1234);
        b1       = WIDTH'(16'hF00D);
        expected = model_product(a1, b1);
        @(posedge clk);
        start        <= 1'b1;
        multiplicand <= a1;
        multiplier   <= b1;
        @(posedge clk);
        start <= 1'b0;
        edges = 0;
        repeat (6) begin
            @(posedge clk);
            edges++;
        end
        start        <= 1'b1;
        multiplicand <= {1'b0, {(WIDTH-1){1'b1}}};
        multiplier   <= {1'b1, {(WIDTH-1){1'b0}}};
        @(posedge clk);
        edges++;
        start <= 1'b0;
        wait_for_ready(edges);
        check_value("ready latency", LATENCY, edges);
        check_value("product", expected, product);
        repeat (IDLE_HOLD) begin
            @(posedge clk);
            @(negedge clk);
            check_value("ready", 1'b0, ready);
            check_value("product", expected, product);
        end
    endtask

    // start held high in the ready cycle starts the next product right away
    task automatic run_back_to_back();
        int                 edges;
        logic [WIDTH-1:0]   a1;
        logic [WIDTH-1:0]   b1;
        logic [WIDTH-1:0]   a2;
        logic [WIDTH-1:0]   b2;
        a1 = WIDTH'($urandom());
        b1 = WIDTH'($urandom());
        a2 = WIDTH'($urandom());
        b2 = WIDTH'($urandom());
        @(posedge clk);
        start        <= 1'b1;
        multiplicand <= a1;
        multiplier   <= b1;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 1; i < LATENCY; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_value("ready", 1'b0, ready);
        end
        // this edge opens the ready cycle
        @(posedge clk);
        start        <= 1'b1;
        multiplicand <= a2;
        multiplier   <= b2;
        @(negedge clk);
        check_value("ready", 1'b1, ready);
        check_value("product", model_product(a1, b1), product);
        // start-sampling edge of the second operation
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value("ready", 1'b0, ready);
        edges = 0;
        wait_for_ready(edges);
        check_value("ready latency", LATENCY, edges);
        check_value("product", model_product(a2, b2), product);
        @(posedge clk);
        @(negedge clk);
        check_value("ready", 1'b0, ready);
    endtask

    initial begin
        start        = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        void'($urandom(SEED));

        check_reset_state();
        run_corner_operands();
        run_random_operands();
        ignore_start_while_busy();
        run_back_to_back();
        run_back_to_back();

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- sim.f
common/booth_pkg.sv
common/booth_ctrl_if.sv
hw/booth_mul/booth_ctrl.sv
hw/booth_mul/booth_datapath.sv
hw/booth_mul_top.sv
testbench/tb_clk_gen.sv
testbench/tb_booth_mul.sv
